//--- hw/chip_io_pkg.sv
////////////////////
// Chip I/O package
// Pad counts, attribute layout, pad variants and fixed pin indices
////////////////////

`default_nettype none

package chip_io_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  parameter int NMioPads = 16;                    // Muxed pads
  parameter int NDioPads = 6;                     // Dedicated pads
  parameter int NumIOs   = NMioPads + NDioPads;   // MIO low bits, DIO high bits

  ////////////////////
  // Pad attributes
  ////////////////////

  parameter int AttrDw     = 2;   // Attribute bits per pad
  parameter int AttrInvIdx = 0;   // Invert in and out
  parameter int AttrOdIdx  = 1;   // Virtual open drain

  // Electrical pad flavour, fixed per pad at build time
  typedef enum logic {
    PAD_BIDIR      = 1'b0,   // Drives high and low
    PAD_OPEN_DRAIN = 1'b1    // Drives low only
  } pad_variant_e;

  ////////////////////
  // Pin indices
  ////////////////////

  // DIO slots of the SPI device pins, reused for JTAG
  parameter int DioPinSpiSck = 5;
  parameter int DioPinSpiCsb = 4;
  parameter int DioPinSpiS0  = 0;
  parameter int DioPinSpiS1  = 1;

  // MIO slots of the strap and JTAG reset pins
  parameter int JtagEnMioIdx = 14;   // JTAG strap
  parameter int TrstMioIdx   = 9;    // TAP reset
  parameter int SrstMioIdx   = 10;   // System reset

endpackage : chip_io_pkg

`default_nettype wire

//--- hw/chip_io_top.sv
////////////////////
// Chip I/O top
// Padring plus JTAG overlay, core side brought out as ports
////////////////////

`default_nettype none

module chip_io_top (
  input  logic                                                       clk_i,
  input  logic                                                       arst_n_i,
  // Muxed IOs, core side
  input  logic [chip_io_pkg::NMioPads-1:0]                           mio_out_i,
  input  logic [chip_io_pkg::NMioPads-1:0]                           mio_oe_i,
  input  logic [chip_io_pkg::NMioPads-1:0][chip_io_pkg::AttrDw-1:0]  mio_attr_i,
  output logic [chip_io_pkg::NMioPads-1:0]                           mio_in_o,
  // Dedicated IOs, core side
  input  logic [chip_io_pkg::NDioPads-1:0]                           dio_out_i,
  input  logic [chip_io_pkg::NDioPads-1:0]                           dio_oe_i,
  input  logic [chip_io_pkg::NDioPads-1:0][chip_io_pkg::AttrDw-1:0]  dio_attr_i,
  output logic [chip_io_pkg::NDioPads-1:0]                           dio_in_o,
  // Pads
  input  logic [chip_io_pkg::NMioPads-1:0]                           mio_pad_in_i,
  output logic [chip_io_pkg::NMioPads-1:0]                           mio_pad_out_o,
  output logic [chip_io_pkg::NMioPads-1:0]                           mio_pad_oe_o,
  input  logic [chip_io_pkg::NDioPads-1:0]                           dio_pad_in_i,
  output logic [chip_io_pkg::NDioPads-1:0]                           dio_pad_out_o,
  output logic [chip_io_pkg::NDioPads-1:0]                           dio_pad_oe_o,
  // JTAG
  output logic                                                       jtag_tck_o,
  output logic                                                       jtag_tms_o,
  output logic                                                       jtag_trst_n_o,
  output logic                                                       jtag_srst_n_o,
  output logic                                                       jtag_tdi_o,
  input  logic                                                       jtag_tdo_i
);

  import chip_io_pkg::*;

  // SPI CSB doubles as TMS and is active low, so it idles high
  localparam logic [NumIOs-1:0] TieOffValues = NumIOs'(1'b1) << (NMioPads + DioPinSpiCsb);

  logic [NumIOs-1:0] out_padring;   // Mux to padring
  logic [NumIOs-1:0] oe_padring;
  logic [NumIOs-1:0] in_padring;    // Padring to mux

  ////////////////////
  // Padring
  ////////////////////

  padring #(
    .NMio       ( NMioPads ),
    .NDio       ( NDioPads ),
    .MioVariant ( {PAD_BIDIR,        // MIO 15
                   PAD_BIDIR,        // MIO 14 JTAG strap
                   PAD_BIDIR, PAD_BIDIR, PAD_BIDIR, PAD_BIDIR, PAD_BIDIR, PAD_BIDIR,
                   PAD_OPEN_DRAIN,   // MIO 7
                   PAD_OPEN_DRAIN,   // MIO 6
                   PAD_BIDIR, PAD_BIDIR,
                   PAD_OPEN_DRAIN,   // MIO 3
                   PAD_OPEN_DRAIN,   // MIO 2
                   PAD_BIDIR, PAD_BIDIR} ),
    .DioVariant ( {NDioPads{PAD_BIDIR}} )   // All DIO bidir
  ) u_padring (
    .clk_i         ( clk_i                           ),
    .arst_n_i      ( arst_n_i                        ),
    .mio_out_i     ( out_padring[NMioPads-1:0]       ),
    .mio_oe_i      ( oe_padring[NMioPads-1:0]        ),
    .mio_attr_i    ( mio_attr_i                      ),
    .mio_in_o      ( in_padring[NMioPads-1:0]        ),
    .dio_out_i     ( out_padring[NumIOs-1:NMioPads]  ),
    .dio_oe_i      ( oe_padring[NumIOs-1:NMioPads]   ),
    .dio_attr_i    ( dio_attr_i                      ),
    .dio_in_o      ( in_padring[NumIOs-1:NMioPads]   ),
    .mio_pad_in_i  ( mio_pad_in_i                    ),
    .mio_pad_out_o ( mio_pad_out_o                   ),
    .mio_pad_oe_o  ( mio_pad_oe_o                    ),
    .dio_pad_in_i  ( dio_pad_in_i                    ),
    .dio_pad_out_o ( dio_pad_out_o                   ),
    .dio_pad_oe_o  ( dio_pad_oe_o                    )
  );

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_mux #(
    .NumIOs         ( NumIOs                  ),
    .TieOffValues   ( TieOffValues            ),
    .JtagEnIdx      ( JtagEnMioIdx            ),
    .JtagEnPolarity ( 1'b1                    ),   // Strap active high
    .TckIdx         ( NMioPads + DioPinSpiSck ),
    .TmsIdx         ( NMioPads + DioPinSpiCsb ),
    .TrstIdx        ( TrstMioIdx              ),
    .SrstIdx        ( SrstMioIdx              ),
    .TdiIdx         ( NMioPads + DioPinSpiS0  ),
    .TdoIdx         ( NMioPads + DioPinSpiS1  )
  ) u_jtag_mux (
    .jtag_tck_o     ( jtag_tck_o              ),
    .jtag_tms_o     ( jtag_tms_o              ),
    .jtag_trst_n_o  ( jtag_trst_n_o           ),
    .jtag_srst_n_o  ( jtag_srst_n_o           ),
    .jtag_tdi_o     ( jtag_tdi_o              ),
    .jtag_tdo_i     ( jtag_tdo_i              ),
    .out_core_i     ( {dio_out_i, mio_out_i}  ),   // DIO in high bits
    .oe_core_i      ( {dio_oe_i, mio_oe_i}    ),
    .in_core_o      ( {dio_in_o, mio_in_o}    ),
    .out_padring_o  ( out_padring             ),
    .oe_padring_o   ( oe_padring              ),
    .in_padring_i   ( in_padring              )
  );

endmodule : chip_io_top

`default_nettype wire

//--- hw/jtag_mux.sv
////////////////////
// JTAG overlay mux
// Strap pin hands fixed pads to the TAP, everything else passes through
////////////////////

`default_nettype none

module jtag_mux #(
  parameter int                NumIOs         = 22,
  parameter logic [NumIOs-1:0] TieOffValues   = '0,     // Core view of JTAG pads
  parameter int                JtagEnIdx      = 14,
  parameter logic              JtagEnPolarity = 1'b1,   // Strap level that enables
  parameter int                TckIdx         = 21,
  parameter int                TmsIdx         = 20,
  parameter int                TrstIdx        = 9,
  parameter int                SrstIdx        = 10,
  parameter int                TdiIdx         = 16,
  parameter int                TdoIdx         = 17
) (
  // TAP side
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_trst_n_o,
  output logic              jtag_srst_n_o,
  output logic              jtag_tdi_o,
  input  logic              jtag_tdo_i,
  // Core side
  input  logic [NumIOs-1:0] out_core_i,
  input  logic [NumIOs-1:0] oe_core_i,
  output logic [NumIOs-1:0] in_core_o,
  // Padring side
  output logic [NumIOs-1:0] out_padring_o,
  output logic [NumIOs-1:0] oe_padring_o,
  input  logic [NumIOs-1:0] in_padring_i
);

  logic jtag_en;   // Overlay active

  // Strap is read after the pad synchronizer, so it lags the pin by two cycles
  assign jtag_en = (in_padring_i[JtagEnIdx] == JtagEnPolarity);

  always_comb begin
    // Default pass through
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    in_core_o     = in_padring_i;

    // TAP idle, held in reset
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b0;
    jtag_trst_n_o = 1'b0;
    jtag_srst_n_o = 1'b1;   // System reset released
    jtag_tdi_o    = 1'b0;

    if (jtag_en) begin
      // TAP inputs from pads
      jtag_tck_o    = in_padring_i[TckIdx];
      jtag_tms_o    = in_padring_i[TmsIdx];
      jtag_trst_n_o = in_padring_i[TrstIdx];
      jtag_srst_n_o = in_padring_i[SrstIdx];
      jtag_tdi_o    = in_padring_i[TdiIdx];

      // Input pads never driven
      oe_padring_o[TckIdx]  = 1'b0;
      oe_padring_o[TmsIdx]  = 1'b0;
      oe_padring_o[TrstIdx] = 1'b0;
      oe_padring_o[SrstIdx] = 1'b0;
      oe_padring_o[TdiIdx]  = 1'b0;

      // TDO owns its pad
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;

      // Core sees idle levels on the borrowed pins
      in_core_o[TckIdx]  = TieOffValues[TckIdx];
      in_core_o[TmsIdx]  = TieOffValues[TmsIdx];
      in_core_o[TrstIdx] = TieOffValues[TrstIdx];
      in_core_o[SrstIdx] = TieOffValues[SrstIdx];
      in_core_o[TdiIdx]  = TieOffValues[TdiIdx];
      in_core_o[TdoIdx]  = TieOffValues[TdoIdx];
    end
  end

endmodule : jtag_mux

`default_nettype wire

//--- hw/pad_cell.sv
////////////////////
// Pad cell
// Output inversion and open drain rule, input synchronizer
////////////////////

`default_nettype none

module pad_cell #(
  parameter chip_io_pkg::pad_variant_e Variant = chip_io_pkg::PAD_BIDIR
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Core side
  input  logic                           out_i,
  input  logic                           oe_i,
  input  logic [chip_io_pkg::AttrDw-1:0] attr_i,
  output logic                           in_o,
  // Board side
  input  logic                           pad_in_i,
  output logic                           pad_out_o,
  output logic                           pad_oe_o
);

  import chip_io_pkg::*;

  localparam bit IsOpenDrain = (Variant == PAD_OPEN_DRAIN);   // Hard open drain cell

  logic inv;          // Inversion attribute
  logic od;           // Open drain, hard or virtual
  logic out_inv;      // Output level after inversion
  logic sync_q1;      // First sync stage
  logic sync_q2;      // Second sync stage

  assign inv     = attr_i[AttrInvIdx];
  assign od      = IsOpenDrain | attr_i[AttrOdIdx];
  assign out_inv = out_i ^ inv;

  // Open drain only pulls low, so a high level releases the pad
  assign pad_out_o = od ? 1'b0 : out_inv;
  assign pad_oe_o  = od ? (oe_i & ~out_inv) : oe_i;

  // Two flop synchronizer on the pad input
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= 1'b0;             // Pad reads low out of reset
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= pad_in_i;         // May go metastable
      sync_q2 <= sync_q1;          // Settled
    end
  end

  assign in_o = sync_q2 ^ inv;     // Core sees inverted level if asked

endmodule : pad_cell

`default_nettype wire

//--- hw/padring.sv
////////////////////
// Padring
// One pad cell per MIO and DIO pad from the variant tables
////////////////////

`default_nettype none

module padring #(
  parameter int                                   NMio       = 16,
  parameter int                                   NDio       = 6,
  parameter chip_io_pkg::pad_variant_e [NMio-1:0] MioVariant = {NMio{chip_io_pkg::PAD_BIDIR}},
  parameter chip_io_pkg::pad_variant_e [NDio-1:0] DioVariant = {NDio{chip_io_pkg::PAD_BIDIR}}
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Muxed IOs, core side
  input  logic [NMio-1:0]                          mio_out_i,
  input  logic [NMio-1:0]                          mio_oe_i,
  input  logic [NMio-1:0][chip_io_pkg::AttrDw-1:0] mio_attr_i,
  output logic [NMio-1:0]                          mio_in_o,
  // Dedicated IOs, core side
  input  logic [NDio-1:0]                          dio_out_i,
  input  logic [NDio-1:0]                          dio_oe_i,
  input  logic [NDio-1:0][chip_io_pkg::AttrDw-1:0] dio_attr_i,
  output logic [NDio-1:0]                          dio_in_o,
  // Muxed pads
  input  logic [NMio-1:0]                          mio_pad_in_i,
  output logic [NMio-1:0]                          mio_pad_out_o,
  output logic [NMio-1:0]                          mio_pad_oe_o,
  // Dedicated pads
  input  logic [NDio-1:0]                          dio_pad_in_i,
  output logic [NDio-1:0]                          dio_pad_out_o,
  output logic [NDio-1:0]                          dio_pad_oe_o
);

  ////////////////////
  // MIO pads
  ////////////////////

  for (genvar i = 0; i < NMio; i++) begin : gen_mio
    pad_cell #(
      .Variant   ( MioVariant[i]    )   // Per pad flavour
    ) u_pad (
      .clk_i     ( clk_i            ),
      .arst_n_i  ( arst_n_i         ),
      .out_i     ( mio_out_i[i]     ),
      .oe_i      ( mio_oe_i[i]      ),
      .attr_i    ( mio_attr_i[i]    ),   // Own attribute slice
      .in_o      ( mio_in_o[i]      ),
      .pad_in_i  ( mio_pad_in_i[i]  ),
      .pad_out_o ( mio_pad_out_o[i] ),
      .pad_oe_o  ( mio_pad_oe_o[i]  )
    );
  end

  ////////////////////
  // DIO pads
  ////////////////////

  for (genvar i = 0; i < NDio; i++) begin : gen_dio
    pad_cell #(
      .Variant   ( DioVariant[i]    )
    ) u_pad (
      .clk_i     ( clk_i            ),
      .arst_n_i  ( arst_n_i         ),
      .out_i     ( dio_out_i[i]     ),
      .oe_i      ( dio_oe_i[i]      ),
      .attr_i    ( dio_attr_i[i]    ),
      .in_o      ( dio_in_o[i]      ),
      .pad_in_i  ( dio_pad_in_i[i]  ),
      .pad_out_o ( dio_pad_out_o[i] ),
      .pad_oe_o  ( dio_pad_oe_o[i]  )
    );
  end

endmodule : padring

`default_nettype wire

//--- project.f
+incdir+include
hw/chip_io_pkg.sv
hw/pad_cell.sv
hw/padring.sv
hw/jtag_mux.sv
hw/chip_io_top.sv
verification/tb_chip_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the chip I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert -f project.f --top-module tb_chip_io -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_chip_io" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- include/tb_vectors.svh
////////////////////
// Testbench vector table
// Directed stimulus with expected pad, core and TAP levels
////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Column order is out, oe, attr, pad_in, tdo, then pad_out, pad_oe, in_core, jtag
// Pad vectors are {dio, mio}
// TAP vector is {tck, tms, trst_n, srst_n, tdi}
localparam int NumTableVecs = 8;

task automatic load_table();
  // Reset levels, TAP idle
  add_vector(22'h000000, 22'h000000, 44'h00000000000, 22'h000000, 1'b0,
             22'h000000, 22'h000000, 22'h000000, 5'b00010);
  // Bidir pass through, no attributes
  add_vector(22'h000033, 22'h000031, 44'h00000000000, 22'h000021, 1'b0,
             22'h000033, 22'h000031, 22'h000021, 5'b00010);
  // Bidir with inversion on MIO 0, MIO 1 and DIO 0
  add_vector(22'h010001, 22'h010003, 44'h00100000005, 22'h000002, 1'b0,
             22'h000002, 22'h010003, 22'h010001, 5'b00010);
  // Open drain MIO 2, 3, 6, 7 with MIO 6 inverted
  add_vector(22'h000088, 22'h0000CC, 44'h00000001000, 22'h0000C0, 1'b0,
             22'h000000, 22'h000004, 22'h000080, 5'b00010);
  // Virtual open drain on MIO 4, MIO 5 (inverted) and DIO 2
  add_vector(22'h040000, 22'h040030, 44'h02000000E00, 22'h040020, 1'b0,
             22'h000000, 22'h000010, 22'h040000, 5'b00010);
  // Strap high, tck tdi trst_n set, core drives every JTAG pad
  add_vector(22'h330601, 22'h330601, 44'h00000000000, 22'h214201, 1'b0,
             22'h310601, 22'h020001, 22'h104001, 5'b10101);
  // Strap high with tms, srst_n and the TDO pad input set, tdo driven high
  add_vector(22'h000001, 22'h000001, 44'h00000000000, 22'h164402, 1'b1,
             22'h020001, 22'h020001, 22'h144002, 5'b01010);
  // Strap dropped, former JTAG pads pass through
  add_vector(22'h330601, 22'h330601, 44'h00000000000, 22'h210200, 1'b1,
             22'h330601, 22'h330601, 22'h210200, 5'b00010);
endtask

`endif

//--- verification/tb_chip_io.sv
////////////////////
// Chip I/O testbench
// Table driven checks of the padring and JTAG overlay
////////////////////

`default_nettype none

module tb_chip_io;

  import chip_io_pkg::*;

  localparam int ClkHalf      = 10;             // Half period
  localparam int ClkPeriod    = 2 * ClkHalf;
  localparam int ResetCycles  = 10;
  localparam int SettleEdges  = 3;              // Two sync flops plus one
  localparam int NumRandom    = 8;              // Extra random entries
  localparam int CyclesPerVec = 5;              // Watchdog budget per entry

  // Bidir pads outside the JTAG set and the strap
  localparam logic [NumIOs-1:0] RandMask = 22'h0CB933;
  localparam logic [4:0]        JtagIdle = 5'b00010;   // TAP in reset, srst released

  typedef struct packed {
    logic [NumIOs-1:0]        out;
    logic [NumIOs-1:0]        oe;
    logic [AttrDw*NumIOs-1:0] attr;             // Pad i at [2i+1:2i]
    logic [NumIOs-1:0]        pad_in;
    logic                     tdo;
    logic [NumIOs-1:0]        exp_pad_out;
    logic [NumIOs-1:0]        exp_pad_oe;
    logic [NumIOs-1:0]        exp_in_core;
    logic [4:0]               exp_jtag;         // {tck, tms, trst_n, srst_n, tdi}
  } vector_t;

  logic                             clk = 1'b0;
  logic                             arst_n;
  logic [NMioPads-1:0]              mio_out;
  logic [NMioPads-1:0]              mio_oe;
  logic [NMioPads-1:0][AttrDw-1:0]  mio_attr;
  logic [NMioPads-1:0]              mio_in;
  logic [NDioPads-1:0]              dio_out;
  logic [NDioPads-1:0]              dio_oe;
  logic [NDioPads-1:0][AttrDw-1:0]  dio_attr;
  logic [NDioPads-1:0]              dio_in;
  logic [NMioPads-1:0]              mio_pad_in;
  logic [NMioPads-1:0]              mio_pad_out;
  logic [NMioPads-1:0]              mio_pad_oe;
  logic [NDioPads-1:0]              dio_pad_in;
  logic [NDioPads-1:0]              dio_pad_out;
  logic [NDioPads-1:0]              dio_pad_oe;
  logic                             jtag_tck;
  logic                             jtag_tms;
  logic                             jtag_trst_n;
  logic                             jtag_srst_n;
  logic                             jtag_tdi;
  logic                             jtag_tdo;

  logic [NumIOs-1:0] pad_out_all;               // {dio, mio} views
  logic [NumIOs-1:0] pad_oe_all;
  logic [NumIOs-1:0] in_core_all;
  logic [4:0]        jtag_all;

  vector_t vectors[$];                          // Table plus random entries

  ////////////////////
  // Clock and DUT
  ////////////////////

  always #ClkHalf clk = ~clk;

  chip_io_top dut (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .mio_out_i     ( mio_out     ),
    .mio_oe_i      ( mio_oe      ),
    .mio_attr_i    ( mio_attr    ),
    .mio_in_o      ( mio_in      ),
    .dio_out_i     ( dio_out     ),
    .dio_oe_i      ( dio_oe      ),
    .dio_attr_i    ( dio_attr    ),
    .dio_in_o      ( dio_in      ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_srst_n_o ( jtag_srst_n ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_tdo_i    ( jtag_tdo    )
  );

  assign pad_out_all = {dio_pad_out, mio_pad_out};
  assign pad_oe_all  = {dio_pad_oe, mio_pad_oe};
  assign in_core_all = {dio_in, mio_in};
  assign jtag_all    = {jtag_tck, jtag_tms, jtag_trst_n, jtag_srst_n, jtag_tdi};

  ////////////////////
  // Helpers
  ////////////////////

  task automatic add_vector(input logic [NumIOs-1:0] out, input logic [NumIOs-1:0] oe,
                            input logic [AttrDw*NumIOs-1:0] attr,
                            input logic [NumIOs-1:0] pad_in, input logic tdo,
                            input logic [NumIOs-1:0] exp_out, input logic [NumIOs-1:0] exp_oe,
                            input logic [NumIOs-1:0] exp_in, input logic [4:0] exp_jtag);
    vector_t v;
    v.out         = out;
    v.oe          = oe;
    v.attr        = attr;
    v.pad_in      = pad_in;
    v.tdo         = tdo;
    v.exp_pad_out = exp_out;
    v.exp_pad_oe  = exp_oe;
    v.exp_in_core = exp_in;
    v.exp_jtag    = exp_jtag;
    vectors.push_back(v);
  endtask

  `include "tb_vectors.svh"

  // Random bidir entry, strap low so the overlay stays off
  function automatic vector_t make_random_vector();
    vector_t           v;
    logic [NumIOs-1:0] inv;
    int                i;
    v        = '0;
    inv      = NumIOs'($urandom()) & RandMask;
    v.out    = NumIOs'($urandom()) & RandMask;
    v.oe     = NumIOs'($urandom()) & RandMask;
    v.pad_in = NumIOs'($urandom()) & RandMask;
    for (i = 0; i < NumIOs; i++) begin
      v.attr[AttrDw*i + AttrInvIdx] = inv[i];   // Inversion only, no od
    end
    v.exp_pad_out = v.out ^ inv;                // Out XOR inv
    v.exp_pad_oe  = v.oe;                       // Bidir oe unchanged
    v.exp_in_core = v.pad_in ^ inv;             // Delayed pad XOR inv
    v.exp_jtag    = JtagIdle;
    return v;
  endfunction

  task automatic apply_vector(input vector_t v);
    @(posedge clk);
    mio_out    <= v.out[NMioPads-1:0];
    dio_out    <= v.out[NumIOs-1:NMioPads];
    mio_oe     <= v.oe[NMioPads-1:0];
    dio_oe     <= v.oe[NumIOs-1:NMioPads];
    mio_attr   <= v.attr[AttrDw*NMioPads-1:0];
    dio_attr   <= v.attr[AttrDw*NumIOs-1:AttrDw*NMioPads];
    mio_pad_in <= v.pad_in[NMioPads-1:0];
    dio_pad_in <= v.pad_in[NumIOs-1:NMioPads];
    jtag_tdo   <= v.tdo;
  endtask

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_vector(input int idx, input vector_t v);
    assert (pad_out_all == v.exp_pad_out) else begin
      $display("Error pad_out entry %0d expected %h got %h", idx, v.exp_pad_out, pad_out_all);
      abort_run();
    end
    assert (pad_oe_all == v.exp_pad_oe) else begin
      $display("Error pad_oe entry %0d expected %h got %h", idx, v.exp_pad_oe, pad_oe_all);
      abort_run();
    end
    assert (in_core_all == v.exp_in_core) else begin
      $display("Error in_core entry %0d expected %h got %h", idx, v.exp_in_core, in_core_all);
      abort_run();
    end
    assert (jtag_all == v.exp_jtag) else begin
      $display("Error jtag entry %0d expected %h got %h", idx, v.exp_jtag, jtag_all);
      abort_run();
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin : watchdog
    #(ClkPeriod * (ResetCycles + CyclesPerVec * (NumTableVecs + NumRandom)));
    $display("Timeout: the vector loop did not finish in time");
    abort_run();
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    int      idx;
    vector_t v;
    void'($urandom(32'h22f2));                  // Seed once
    arst_n     = 1'b0;
    mio_out    = '0;
    mio_oe     = '0;
    mio_attr   = '0;
    dio_out    = '0;
    dio_oe     = '0;
    dio_attr   = '0;
    mio_pad_in = '0;
    dio_pad_in = '0;
    jtag_tdo   = 1'b0;
    load_table();
    for (idx = 0; idx < NumRandom; idx++) begin
      vectors.push_back(make_random_vector());
    end
    repeat (ResetCycles) @(posedge clk);
    arst_n <= 1'b1;                             // Release reset
    for (idx = 0; idx < vectors.size(); idx++) begin
      v = vectors[idx];
      apply_vector(v);
      repeat (SettleEdges) @(posedge clk);      // Sync flops settle
      @(negedge clk);                           // Sample away from edge
      check_vector(idx, v);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule : tb_chip_io

`default_nettype wire
